// ==== rv_pkg.sv ====
package rv_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;

  localparam word_t RESET_PC   = 32'h0000_0000;
  // 4 KiB timer window
  localparam word_t TIMER_BASE = 32'h0200_0000;
  localparam word_t TIMER_MASK = 32'hFFFF_F000;

  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_PASS_B
  } alu_op_e;

  typedef enum logic [2:0] {
    OP_ALU, OP_LOAD, OP_STORE, OP_BEQ, OP_BNE, OP_JAL, OP_NOP
  } op_class_e;

  typedef enum logic [1:0] {FETCH_IDLE, FETCH_REQ, FETCH_WAIT} fetch_state_e;

  typedef enum logic [1:0] {EXEC_READY, EXEC_MEM, EXEC_RETIRE} exec_state_e;

  typedef struct packed {
    op_class_e op;
    alu_op_e   alu;
    reg_addr_t rd;
    word_t     rs1_val;
    word_t     rs2_val;
    word_t     imm;
    logic      use_imm;
    word_t     pc;
  } decoded_t;

  typedef struct packed {
    logic  valid;
    logic  write;
    word_t addr;
    word_t wdata;
  } mem_req_t;

  typedef struct packed {
    logic  valid;
    word_t rdata;
  } mem_resp_t;

  typedef struct packed {
    logic      valid;
    word_t     pc;
    logic      we;
    reg_addr_t rd;
    word_t     wdata;
  } retire_t;

endpackage

// ==== rv_regfile.sv ====
`timescale 1ns/1ps

module rv_regfile
  import rv_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  reg_addr_t raddr1,
  input  reg_addr_t raddr2,
  output word_t     rdata1,
  output word_t     rdata2,
  input  logic      we,
  input  reg_addr_t waddr,
  input  word_t     wdata
);

  // x0 has no storage
  word_t regs [1:31];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== rv_fetch.sv ====
`timescale 1ns/1ps

module rv_fetch
  import rv_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  word_t     npc,
  input  logic      npc_valid,
  output logic      inst_valid,
  input  logic      inst_ready,
  output word_t     inst,
  output word_t     pc,
  output mem_req_t  ifetch_req,
  input  mem_resp_t ifetch_resp
);

  fetch_state_e state;
  word_t        pc_q;
  word_t        inst_q;

  // Leaves reset already requesting RESET_PC
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= FETCH_REQ;
      pc_q  <= RESET_PC;
    end else begin
      unique case (state)
        FETCH_IDLE: begin
          if (npc_valid) begin
            pc_q  <= npc;
            state <= FETCH_REQ;
          end
        end
        FETCH_REQ: begin
          if (ifetch_resp.valid) state <= FETCH_WAIT;
        end
        default: begin
          if (inst_ready) state <= FETCH_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == FETCH_REQ && ifetch_resp.valid) inst_q <= ifetch_resp.rdata;
  end

  // Held until the response, the crossbar masks it once accepted
  always_comb begin
    ifetch_req.valid = (state == FETCH_REQ);
    ifetch_req.write = 1'b0;
    ifetch_req.addr  = pc_q;
    ifetch_req.wdata = '0;
  end

  assign inst_valid = (state == FETCH_WAIT);
  assign inst       = inst_q;
  assign pc         = pc_q;

endmodule

// ==== rv_decode.sv ====
`timescale 1ns/1ps

module rv_decode
  import rv_pkg::*;
(
  input  word_t     inst,
  input  word_t     pc,
  output reg_addr_t rs1,
  output reg_addr_t rs2,
  input  word_t     rdata1,
  input  word_t     rdata2,
  output decoded_t  dec
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_addr_t  rd_f;
  word_t      imm_i, imm_s, imm_b, imm_u, imm_j;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];
  assign rd_f   = inst[11:7];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  // rd stays zero for anything that does not write back
  always_comb begin
    dec         = '0;
    dec.op      = OP_NOP;
    dec.alu     = ALU_ADD;
    dec.rs1_val = rdata1;
    dec.rs2_val = rdata2;
    dec.pc      = pc;
    case (opcode)
      OPC_LUI: begin
        dec.op      = OP_ALU;
        dec.alu     = ALU_PASS_B;
        dec.rd      = rd_f;
        dec.imm     = imm_u;
        dec.use_imm = 1'b1;
      end
      OPC_OP_IMM: begin
        if (funct3 == 3'b000) begin
          dec.op      = OP_ALU;
          dec.rd      = rd_f;
          dec.imm     = imm_i;
          dec.use_imm = 1'b1;
        end
      end
      OPC_OP: begin
        dec.op = OP_ALU;
        dec.rd = rd_f;
        case ({funct7, funct3})
          10'b0000000_000: dec.alu = ALU_ADD;
          10'b0100000_000: dec.alu = ALU_SUB;
          10'b0000000_111: dec.alu = ALU_AND;
          10'b0000000_110: dec.alu = ALU_OR;
          10'b0000000_100: dec.alu = ALU_XOR;
          10'b0000000_010: dec.alu = ALU_SLT;
          default: begin
            dec.op = OP_NOP;
            dec.rd = '0;
          end
        endcase
      end
      OPC_LOAD: begin
        if (funct3 == 3'b010) begin
          dec.op      = OP_LOAD;
          dec.rd      = rd_f;
          dec.imm     = imm_i;
          dec.use_imm = 1'b1;
        end
      end
      OPC_STORE: begin
        if (funct3 == 3'b010) begin
          dec.op      = OP_STORE;
          dec.imm     = imm_s;
          dec.use_imm = 1'b1;
        end
      end
      OPC_BRANCH: begin
        dec.imm = imm_b;
        if (funct3 == 3'b000) dec.op = OP_BEQ;
        else if (funct3 == 3'b001) dec.op = OP_BNE;
      end
      OPC_JAL: begin
        dec.op  = OP_JAL;
        dec.rd  = rd_f;
        dec.imm = imm_j;
      end
      default: ;
    endcase
  end

endmodule

// ==== rv_execute.sv ====
`timescale 1ns/1ps

module rv_execute
  import rv_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  decoded_t  dec,
  input  logic      inst_valid,
  output logic      inst_ready,
  output word_t     npc,
  output logic      npc_valid,
  output logic      rf_we,
  output reg_addr_t rf_waddr,
  output word_t     rf_wdata,
  output mem_req_t  lsu_req,
  input  mem_resp_t lsu_resp,
  output retire_t   retire
);

  exec_state_e state;
  decoded_t    d_q;
  word_t       ld_q;
  word_t       alu_b, alu_res, pc_plus4, wb_data;
  logic        taken, wr_en, retiring;

  assign inst_ready = (state == EXEC_READY);
  assign retiring   = (state == EXEC_RETIRE);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= EXEC_READY;
    end else begin
      unique case (state)
        EXEC_READY: begin
          if (inst_valid) begin
            if (dec.op == OP_LOAD || dec.op == OP_STORE) state <= EXEC_MEM;
            else state <= EXEC_RETIRE;
          end
        end
        EXEC_MEM: begin
          if (lsu_resp.valid) state <= EXEC_RETIRE;
        end
        default: state <= EXEC_READY;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (inst_ready && inst_valid) d_q <= dec;
    if (state == EXEC_MEM && lsu_resp.valid) ld_q <= lsu_resp.rdata;
  end

  // Loads and stores use the ADD result as their address
  always_comb begin
    alu_b = d_q.use_imm ? d_q.imm : d_q.rs2_val;
    unique case (d_q.alu)
      ALU_ADD: alu_res = d_q.rs1_val + alu_b;
      ALU_SUB: alu_res = d_q.rs1_val - alu_b;
      ALU_AND: alu_res = d_q.rs1_val & alu_b;
      ALU_OR:  alu_res = d_q.rs1_val | alu_b;
      ALU_XOR: alu_res = d_q.rs1_val ^ alu_b;
      ALU_SLT: alu_res = {31'b0, $signed(d_q.rs1_val) < $signed(alu_b)};
      default: alu_res = alu_b;
    endcase
  end

  always_comb begin
    pc_plus4 = d_q.pc + 32'd4;
    taken    = (d_q.op == OP_JAL) ||
               (d_q.op == OP_BEQ && d_q.rs1_val == d_q.rs2_val) ||
               (d_q.op == OP_BNE && d_q.rs1_val != d_q.rs2_val);
    npc      = taken ? d_q.pc + d_q.imm : pc_plus4;
    wr_en    = (d_q.op inside {OP_ALU, OP_LOAD, OP_JAL}) && d_q.rd != '0;
    case (d_q.op)
      OP_LOAD: wb_data = ld_q;
      OP_JAL:  wb_data = pc_plus4;
      default: wb_data = alu_res;
    endcase
  end

  assign npc_valid = retiring;
  assign rf_we     = retiring && wr_en;
  assign rf_waddr  = d_q.rd;
  assign rf_wdata  = wb_data;

  always_comb begin
    lsu_req.valid = (state == EXEC_MEM);
    lsu_req.write = (d_q.op == OP_STORE);
    lsu_req.addr  = alu_res;
    lsu_req.wdata = d_q.rs2_val;
  end

  always_comb begin
    retire.valid = retiring;
    retire.pc    = d_q.pc;
    retire.we    = rf_we;
    retire.rd    = d_q.rd;
    retire.wdata = rf_we ? wb_data : '0;
  end

endmodule

// ==== rv_lsu.sv ====
`timescale 1ns/1ps

module rv_lsu
  import rv_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  mem_req_t  lsu_req,
  output mem_resp_t lsu_resp,
  output mem_req_t  data_req,
  input  mem_resp_t data_resp
);

  // Set once the response is back, clears when execute drops its request
  logic done;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      done <= 1'b0;
    end else if (data_resp.valid) begin
      done <= 1'b1;
    end else if (!lsu_req.valid) begin
      done <= 1'b0;
    end
  end

  always_comb begin
    data_req.valid = lsu_req.valid && !done;
    data_req.write = lsu_req.write;
    data_req.addr  = {lsu_req.addr[31:2], 2'b00};
    data_req.wdata = lsu_req.wdata;
  end

  always_comb begin
    lsu_resp.valid = data_resp.valid && lsu_req.valid;
    lsu_resp.rdata = data_resp.rdata;
  end

endmodule

// ==== rv_xbar.sv ====
`timescale 1ns/1ps

module rv_xbar
  import rv_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  mem_req_t  ifetch_req,
  input  mem_req_t  data_req,
  output logic      ifetch_ready,
  output logic      data_ready,
  output mem_resp_t ifetch_resp,
  output mem_resp_t data_resp,
  output mem_req_t  mem_req,
  input  logic      mem_req_ready,
  input  mem_resp_t mem_resp
);

  logic     busy, own_data, tmr_pend;
  logic     stall_q, stall_data_q;
  word_t    mtime;
  logic     sel_data, hit_timer, grant_ready, accept;
  logic     resp_valid;
  word_t    resp_rdata;
  mem_req_t sel_req;

  // A stalled external request keeps its source until accepted
  always_comb begin
    sel_data     = stall_q ? stall_data_q : data_req.valid;
    sel_req      = sel_data ? data_req : ifetch_req;
    hit_timer    = (sel_req.addr & TIMER_MASK) == TIMER_BASE;
    grant_ready  = !busy && (hit_timer || mem_req_ready);
    data_ready   = grant_ready && sel_data;
    ifetch_ready = grant_ready && !sel_data;
    accept       = (data_req.valid && data_ready) || (ifetch_req.valid && ifetch_ready);
  end

  always_comb begin
    mem_req       = sel_req;
    mem_req.valid = sel_req.valid && !busy && !hit_timer;
  end

  always_comb begin
    resp_valid = busy && (tmr_pend || mem_resp.valid);
    resp_rdata = tmr_pend ? mtime : mem_resp.rdata;
    ifetch_resp.valid = resp_valid && !own_data;
    ifetch_resp.rdata = resp_rdata;
    data_resp.valid   = resp_valid && own_data;
    data_resp.rdata   = resp_rdata;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy         <= 1'b0;
      own_data     <= 1'b0;
      tmr_pend     <= 1'b0;
      stall_q      <= 1'b0;
      stall_data_q <= 1'b0;
      mtime        <= '0;
    end else begin
      mtime        <= mtime + 32'd1;
      stall_q      <= mem_req.valid && !mem_req_ready;
      stall_data_q <= sel_data;
      if (accept) begin
        busy     <= 1'b1;
        own_data <= sel_data;
        // Timer writes are acked here and dropped
        tmr_pend <= hit_timer;
      end else if (resp_valid) begin
        busy     <= 1'b0;
        tmr_pend <= 1'b0;
      end
    end
  end

endmodule

// ==== rv_core.sv ====
`timescale 1ns/1ps

module rv_core
  import rv_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  output mem_req_t  mem_req,
  input  logic      mem_req_ready,
  input  mem_resp_t mem_resp,
  output retire_t   retire
);

  reg_addr_t rs1, rs2;
  word_t     rdata1, rdata2;
  logic      rf_we;
  reg_addr_t rf_waddr;
  word_t     rf_wdata;

  word_t     inst, pc, npc;
  logic      inst_valid, inst_ready, npc_valid;
  decoded_t  dec;

  mem_req_t  ifetch_req, data_req, lsu_req;
  mem_resp_t ifetch_resp, data_resp, lsu_resp;

  rv_regfile i_regfile (
    .clk    (clk),
    .rst_n  (rst_n),
    .raddr1 (rs1),
    .raddr2 (rs2),
    .rdata1 (rdata1),
    .rdata2 (rdata2),
    .we     (rf_we),
    .waddr  (rf_waddr),
    .wdata  (rf_wdata)
  );

  rv_fetch i_fetch (
    .clk         (clk),
    .rst_n       (rst_n),
    .npc         (npc),
    .npc_valid   (npc_valid),
    .inst_valid  (inst_valid),
    .inst_ready  (inst_ready),
    .inst        (inst),
    .pc          (pc),
    .ifetch_req  (ifetch_req),
    .ifetch_resp (ifetch_resp)
  );

  rv_decode i_decode (
    .inst   (inst),
    .pc     (pc),
    .rs1    (rs1),
    .rs2    (rs2),
    .rdata1 (rdata1),
    .rdata2 (rdata2),
    .dec    (dec)
  );

  rv_execute i_execute (
    .clk        (clk),
    .rst_n      (rst_n),
    .dec        (dec),
    .inst_valid (inst_valid),
    .inst_ready (inst_ready),
    .npc        (npc),
    .npc_valid  (npc_valid),
    .rf_we      (rf_we),
    .rf_waddr   (rf_waddr),
    .rf_wdata   (rf_wdata),
    .lsu_req    (lsu_req),
    .lsu_resp   (lsu_resp),
    .retire     (retire)
  );

  rv_lsu i_lsu (
    .clk       (clk),
    .rst_n     (rst_n),
    .lsu_req   (lsu_req),
    .lsu_resp  (lsu_resp),
    .data_req  (data_req),
    .data_resp (data_resp)
  );

  // Sources hold their request until the response, so ready is internal
  rv_xbar i_xbar (
    .clk           (clk),
    .rst_n         (rst_n),
    .ifetch_req    (ifetch_req),
    .data_req      (data_req),
    .ifetch_ready  (),
    .data_ready    (),
    .ifetch_resp   (ifetch_resp),
    .data_resp     (data_resp),
    .mem_req       (mem_req),
    .mem_req_ready (mem_req_ready),
    .mem_resp      (mem_resp)
  );

endmodule

// ==== rv_core_props.sv ====
`timescale 1ns/1ps

module rv_core_props
  import rv_pkg::*;
(
  input logic      clk,
  input logic      rst_n,
  input mem_req_t  mem_req,
  input logic      mem_req_ready,
  input retire_t   retire
);

  // Stalled request holds every field
  assert property (@(posedge clk) disable iff (!rst_n)
    (mem_req.valid && !mem_req_ready) |=> $stable(mem_req))
    else $error("mem_req changed while stalled");

  assert property (@(posedge clk) disable iff (!rst_n)
    (retire.valid && retire.we) |-> (retire.rd != '0))
    else $error("retire reports a write to x0");

  assert property (@(posedge clk) $rose(rst_n) |-> !retire.valid)
    else $error("retire.valid high right after reset release");

endmodule

bind rv_core rv_core_props i_props (
  .clk           (clk),
  .rst_n         (rst_n),
  .mem_req       (mem_req),
  .mem_req_ready (mem_req_ready),
  .retire        (retire)
);

// ==== tb_rv_core.sv ====
`timescale 1ns/1ps

module tb_rv_core
  import rv_pkg::*;
();

  localparam logic [1:0] RUN = 2'd0, SKIP = 2'd1, TIMER = 2'd2;
  localparam logic [6:0] OPI = 7'b0010011, LOAD = 7'b0000011;
  localparam word_t STORE_ADDR = 32'h0000_0108;
  localparam word_t STORE_VAL  = 32'h1234_5064;

  typedef struct packed {
    word_t      inst;
    word_t      pc;
    logic       we;
    reg_addr_t  rd;
    word_t      value;
    logic [1:0] kind;
  } step_t;

  logic        clk = 1'b0;
  logic        rst_n = 1'b0;
  mem_req_t    mem_req;
  logic        mem_req_ready = 1'b0;
  mem_resp_t   mem_resp = '0;
  retire_t     retire;

  step_t       prog [$];
  word_t       mem [0:255];
  word_t       resp_data;
  int unsigned resp_wait = 0, stall_left = 0, lcg_state = 78;
  int          cycles = 0, limit = 0, retired = 0, val_errs = 0, other_errs = 0;

  rv_core i_dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .mem_req       (mem_req),
    .mem_req_ready (mem_req_ready),
    .mem_resp      (mem_resp),
    .retire        (retire)
  );

  always #10 clk = ~clk;

  function automatic int unsigned next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state >> 16;
  endfunction

  function automatic word_t r_type(input logic [6:0] f7, input logic [2:0] f3,
                                   input reg_addr_t rd, input reg_addr_t rs1,
                                   input reg_addr_t rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic word_t i_type(input logic [6:0] opc, input logic [2:0] f3,
                                   input reg_addr_t rd, input reg_addr_t rs1,
                                   input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t s_type(input reg_addr_t rs1, input reg_addr_t rs2,
                                   input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic word_t b_type(input logic [2:0] f3, input reg_addr_t rs1,
                                   input reg_addr_t rs2, input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic word_t u_type(input reg_addr_t rd, input logic [19:0] imm);
    return {imm, rd, 7'b0110111};
  endfunction

  function automatic word_t j_type(input reg_addr_t rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  // PC follows the position in the table
  task automatic add_step(input word_t inst, input logic we, input reg_addr_t rd,
                          input word_t value, input logic [1:0] kind);
    step_t s;
    s.inst  = inst;
    s.pc    = word_t'(prog.size() * 4);
    s.we    = we;
    s.rd    = rd;
    s.value = value;
    s.kind  = kind;
    prog.push_back(s);
  endtask

  // Memory with random accept stalls and response delays
  always @(posedge clk) begin
    word_t       rd_word;
    int unsigned delay;
    int unsigned stall;
    if (rst_n) begin
      mem_resp.valid <= 1'b0;
      if (resp_wait == 1) begin
        mem_resp.valid <= 1'b1;
        mem_resp.rdata <= resp_data;
      end
      if (resp_wait != 0) resp_wait <= resp_wait - 1;
      if (mem_req.valid && (mem_req.addr & TIMER_MASK) == TIMER_BASE) begin
        $display("External request seen for timer address %h", mem_req.addr);
        other_errs++;
      end
      if (mem_req.valid && mem_req_ready) begin
        rd_word = mem_req.write ? '0 : mem[mem_req.addr[9:2]];
        if (mem_req.write) mem[mem_req.addr[9:2]] = mem_req.wdata;
        delay = 1 + next_rand() % 3;
        if (delay == 1) begin
          mem_resp.valid <= 1'b1;
          mem_resp.rdata <= rd_word;
        end else begin
          resp_data <= rd_word;
          resp_wait <= delay - 1;
        end
        stall = next_rand() % 4;
        stall_left    <= stall;
        mem_req_ready <= (stall == 0);
      end else if (mem_req.valid && !mem_req_ready) begin
        if (stall_left > 1) begin
          stall_left <= stall_left - 1;
        end else begin
          stall_left    <= 0;
          mem_req_ready <= 1'b1;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit != 0 && cycles >= limit) begin
      $display("Timeout after %0d cycles, the core stopped retiring", cycles);
      $display("Testbench failed");
      $finish;
    end
  end

  initial begin
    word_t prev_tmr;
    logic  have_tmr;
    have_tmr = 1'b0;
    prev_tmr = '0;

    add_step(u_type(1, 20'h12345), 1, 1, 32'h1234_5000, RUN);
    add_step(i_type(OPI, 3'b000, 2, 0, 12'd100), 1, 2, 32'h0000_0064, RUN);
    add_step(i_type(OPI, 3'b000, 3, 0, 12'hFF9), 1, 3, 32'hFFFF_FFF9, RUN);
    add_step(r_type(7'h00, 3'b000, 4, 1, 2), 1, 4, STORE_VAL, RUN);
    add_step(r_type(7'h20, 3'b000, 5, 2, 3), 1, 5, 32'h0000_006B, RUN);
    add_step(r_type(7'h00, 3'b111, 6, 1, 4), 1, 6, 32'h1234_5000, RUN);
    add_step(r_type(7'h00, 3'b110, 7, 2, 3), 1, 7, 32'hFFFF_FFFD, RUN);
    add_step(r_type(7'h00, 3'b100, 8, 2, 3), 1, 8, 32'hFFFF_FF9D, RUN);
    add_step(r_type(7'h00, 3'b010, 9, 3, 2), 1, 9, 32'h0000_0001, RUN);
    add_step(r_type(7'h00, 3'b010, 10, 2, 3), 1, 10, 32'h0000_0000, RUN);
    // Write to x0 is dropped, then x0 is read back
    add_step(i_type(OPI, 3'b000, 0, 2, 12'd5), 0, 0, 32'h0, RUN);
    add_step(r_type(7'h00, 3'b000, 11, 0, 2), 1, 11, 32'h0000_0064, RUN);
    add_step(i_type(OPI, 3'b000, 12, 0, 12'h100), 1, 12, 32'h0000_0100, RUN);
    add_step(s_type(12, 4, 12'd8), 0, 0, 32'h0, RUN);
    add_step(i_type(LOAD, 3'b010, 13, 12, 12'd8), 1, 13, STORE_VAL, RUN);
    // Slots jumped over by taken branches never retire
    add_step(b_type(3'b000, 2, 11, 13'd8), 0, 0, 32'h0, RUN);
    add_step(i_type(OPI, 3'b000, 14, 0, 12'd1), 0, 0, 32'h0, SKIP);
    add_step(b_type(3'b001, 2, 11, 13'd8), 0, 0, 32'h0, RUN);
    add_step(b_type(3'b000, 2, 3, 13'd8), 0, 0, 32'h0, RUN);
    add_step(b_type(3'b001, 2, 3, 13'd8), 0, 0, 32'h0, RUN);
    add_step(i_type(OPI, 3'b000, 14, 0, 12'd2), 0, 0, 32'h0, SKIP);
    add_step(j_type(15, 21'd8), 1, 15, 32'h0000_0058, RUN);
    add_step(i_type(OPI, 3'b000, 14, 0, 12'd3), 0, 0, 32'h0, SKIP);
    add_step(u_type(16, TIMER_BASE[31:12]), 1, 16, TIMER_BASE, RUN);
    add_step(i_type(LOAD, 3'b010, 17, 16, 12'd0), 1, 17, 32'h0, TIMER);
    add_step(i_type(LOAD, 3'b010, 18, 16, 12'd0), 1, 18, 32'h0, TIMER);
    add_step(i_type(OPI, 3'b000, 20, 14, 12'd9), 1, 20, 32'h0000_0009, RUN);
    // Parks the core in a self loop
    add_step(j_type(0, 21'd0), 0, 0, 32'h0, RUN);

    for (int i = 0; i < 256; i++) begin
      mem[i] = 32'hA5A5_0000 ^ word_t'(i * 4);
    end
    foreach (prog[i]) begin
      mem[prog[i].pc[9:2]] = prog[i].inst;
    end
    limit = prog.size() * 16;

    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    for (int i = 0; i < prog.size(); i++) begin
      if (prog[i].kind != SKIP) begin
        @(negedge clk);
        while (!retire.valid) @(negedge clk);
        retired++;
        if (retire.pc !== prog[i].pc) begin
          $display("** Error: retire.pc step %0d got %h expected %h", i, retire.pc, prog[i].pc);
          val_errs++;
        end
        if (retire.we !== prog[i].we) begin
          $display("** Error: retire.we step %0d got %h expected %h", i, retire.we, prog[i].we);
          val_errs++;
        end
        if (retire.rd !== prog[i].rd) begin
          $display("** Error: retire.rd step %0d got %h expected %h", i, retire.rd, prog[i].rd);
          val_errs++;
        end
        if (prog[i].kind == TIMER) begin
          if (have_tmr && !(retire.wdata > prev_tmr)) begin
            $display("** Error: retire.wdata timer step %0d got %h expected above %h",
                     i, retire.wdata, prev_tmr);
            val_errs++;
          end
          prev_tmr = retire.wdata;
          have_tmr = 1'b1;
        end else if (retire.wdata !== prog[i].value) begin
          $display("** Error: retire.wdata step %0d got %h expected %h",
                   i, retire.wdata, prog[i].value);
          val_errs++;
        end
      end
    end

    if (mem[STORE_ADDR[9:2]] !== STORE_VAL) begin
      $display("** Error: mem[%h] got %h expected %h", STORE_ADDR, mem[STORE_ADDR[9:2]],
               STORE_VAL);
      val_errs++;
    end

    $display("Retired %0d instructions, %0d value errors, %0d other errors",
             retired, val_errs, other_errs);
    if (val_errs == 0 && other_errs == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== rv_core.f ====
rv_pkg.sv
rv_regfile.sv
rv_fetch.sv
rv_decode.sv
rv_execute.sv
rv_lsu.sv
rv_xbar.sv
rv_core.sv
rv_core_props.sv
tb_rv_core.sv
